// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam logic [31:0] START_ADDR = 32'h0000_0100;
  localparam int FETCH_BURST = 4; // requests per burst
  localparam int FIFO_AWIDTH = 4;
  localparam int NREGS = 16;

  // instruction bits [4:1]
  typedef enum logic [3:0] {
    OP_NOP = 4'd0,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_LDI,
    OP_JMP,
    OP_HALT
  } opcode_t;

  typedef enum logic [1:0] {
    F_RESET,
    F_WORD1,
    F_WORD2
  } fetch_state_t;

  typedef enum logic [1:0] {
    B_IDLE,
    B_REQ,
    B_DRAIN,
    B_HALT
  } bus_state_t;

  typedef struct packed {
    logic        valid;
    opcode_t     op;
    logic [3:0]  rd;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [31:0] imm; // sign extended or long word
    logic [31:0] pc;
  } dec_t;

endpackage

`default_nettype wire

// File: hdl/core_ifs.sv
`default_nettype none
`timescale 1ns/1ps

interface wb_if;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [3:0]  sel;
  logic [31:0] adr;
  logic [31:0] dat_s; // read data from slave
  logic        ack;
  logic        stall;

  modport master (
    output cyc, stb, we, sel, adr,
    input  dat_s, ack, stall
  );

  modport slave (
    input  cyc, stb, we, sel, adr,
    output dat_s, ack, stall
  );
endinterface

interface fetch_if;
  logic [63:0] ir; // zero is a bubble
  logic [31:0] pc;

  modport src (
    output ir, pc
  );

  modport dst (
    input  ir, pc
  );
endinterface

interface rf_if;
  logic [3:0]  ra;
  logic [3:0]  rb;
  logic        we;
  logic [3:0]  wa;
  logic [31:0] wd;
  logic [31:0] rdata_a;
  logic [31:0] rdata_b;

  modport ctl (
    output ra, rb, we, wa, wd,
    input  rdata_a, rdata_b
  );

  modport regs (
    input  ra, rb, we, wa, wd,
    output rdata_a, rdata_b
  );
endinterface

`default_nettype wire

// File: hdl/fetch_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_fifo
(
  input  wire                            clk_i,
  input  wire                            rst_i,
  input  wire                            flush_i,
  input  wire                            push_i,
  input  wire [31:0]                     data_i,
  input  wire                            pop_i,
  output logic [31:0]                    data_o,
  output logic [core_pkg::FIFO_AWIDTH:0] count_o,
  output logic                           empty_o
);

  logic [31:0] mem [2**core_pkg::FIFO_AWIDTH];
  logic [core_pkg::FIFO_AWIDTH:0] wr_ptr; // extra bit tells full from empty
  logic [core_pkg::FIFO_AWIDTH:0] rd_ptr;
  logic do_push;
  logic do_pop;

  assign count_o = wr_ptr - rd_ptr;
  assign empty_o = (wr_ptr == rd_ptr);
  assign do_push = push_i && !count_o[core_pkg::FIFO_AWIDTH];
  assign do_pop = pop_i && !empty_o;
  assign data_o = mem[rd_ptr[core_pkg::FIFO_AWIDTH-1:0]]; // fall through

  always_ff @(posedge clk_i)
  begin
    if (rst_i || flush_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (do_push && !flush_i)
      mem[wr_ptr[core_pkg::FIFO_AWIDTH-1:0]] <= data_i;
  end

endmodule

`default_nettype wire

// File: hdl/ifetch.sv
`default_nettype none
`timescale 1ns/1ps

module ifetch
(
  input  wire        clk_i,
  input  wire        rst_i,
  wb_if.master       bus,
  fetch_if.src       fo,
  input  wire        pc_set_i,
  input  wire [31:0] pc_in_i,
  input  wire        halt_i,
  input  wire        stall_i
);

  core_pkg::bus_state_t bus_state, bus_state_next;
  core_pkg::fetch_state_t state, state_next;
  logic [$clog2(core_pkg::FETCH_BURST):0] req_cnt, req_cnt_next;
  logic [$clog2(core_pkg::FETCH_BURST):0] ack_cnt, ack_cnt_next;
  logic [31:0] adr_next;
  logic drop, drop_next;
  logic [31:0] fetch_pc, fetch_pc_next;
  logic [31:0] low, low_next;
  logic [63:0] ir_next;
  logic [31:0] pc_next;
  logic [31:0] word;
  logic [core_pkg::FIFO_AWIDTH:0] fifo_count;
  logic fifo_empty;
  logic push;
  logic pop;
  logic req_ok;
  logic room;

  assign bus.cyc = (bus_state == core_pkg::B_REQ) || (bus_state == core_pkg::B_DRAIN);
  assign bus.stb = (bus_state == core_pkg::B_REQ) && !halt_i;
  assign bus.we = 1'b0;
  assign bus.sel = 4'hf;

  assign req_ok = bus.stb && !bus.stall;
  assign push = bus.cyc && bus.ack && !drop && !pc_set_i; // stale acks dropped
  assign room = int'(fifo_count) <=
                (1 << core_pkg::FIFO_AWIDTH) - core_pkg::FETCH_BURST;
  assign pop = !stall_i && !fifo_empty && !pc_set_i && (state != core_pkg::F_RESET);

  fetch_fifo u_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (pc_set_i),
    .push_i  (push),
    .data_i  (bus.dat_s),
    .pop_i   (pop),
    .data_o  (word),
    .count_o (fifo_count),
    .empty_o (fifo_empty)
  );

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      bus_state <= core_pkg::B_IDLE;
      bus.adr <= core_pkg::START_ADDR;
      req_cnt <= '0;
      ack_cnt <= '0;
      drop <= 1'b0;
      state <= core_pkg::F_RESET;
      fetch_pc <= core_pkg::START_ADDR;
      fo.ir <= '0;
    end
    else
    begin
      bus_state <= bus_state_next;
      bus.adr <= adr_next;
      req_cnt <= req_cnt_next;
      ack_cnt <= ack_cnt_next;
      drop <= drop_next;
      state <= state_next;
      fetch_pc <= fetch_pc_next;
      fo.ir <= ir_next;
    end
  end

  always_ff @(posedge clk_i)
  begin
    low <= low_next;
    fo.pc <= pc_next;
  end

  // bus engine
  always_comb
  begin
    bus_state_next = bus_state;
    adr_next = bus.adr;
    req_cnt_next = req_cnt;
    ack_cnt_next = ack_cnt;
    drop_next = drop;
    if (bus.cyc && bus.ack)
      ack_cnt_next = ack_cnt + 1'b1;
    if (req_ok)
    begin
      adr_next = bus.adr + 32'd4;
      req_cnt_next = req_cnt + 1'b1;
    end
    case (bus_state)
      core_pkg::B_IDLE:
      begin
        req_cnt_next = '0;
        ack_cnt_next = '0;
        drop_next = 1'b0;
        if (halt_i)
          bus_state_next = core_pkg::B_HALT;
        else if (pc_set_i)
          adr_next = pc_in_i;
        else if (room)
          bus_state_next = core_pkg::B_REQ;
      end
      core_pkg::B_REQ:
      begin
        if (pc_set_i)
        begin
          adr_next = pc_in_i;
          drop_next = 1'b1; // acks still owed
          bus_state_next = core_pkg::B_DRAIN;
        end
        else if (halt_i || (req_ok && int'(req_cnt) == core_pkg::FETCH_BURST - 1))
          bus_state_next = core_pkg::B_DRAIN;
      end
      core_pkg::B_DRAIN:
      begin
        if (pc_set_i)
          adr_next = pc_in_i;
        if (ack_cnt_next == req_cnt)
        begin
          drop_next = 1'b0;
          bus_state_next = halt_i ? core_pkg::B_HALT : core_pkg::B_IDLE;
        end
        else if (pc_set_i)
          drop_next = 1'b1;
      end
      core_pkg::B_HALT:
        bus_state_next = core_pkg::B_HALT;
      default:
        bus_state_next = core_pkg::B_IDLE;
    endcase
  end

  // instruction assembler
  always_comb
  begin
    state_next = state;
    fetch_pc_next = fetch_pc;
    low_next = low;
    ir_next = fo.ir;
    pc_next = fo.pc;
    if (!stall_i)
      ir_next = '0; // bubble unless a word completes
    case (state)
      core_pkg::F_RESET:
        state_next = core_pkg::F_WORD1;
      core_pkg::F_WORD1:
        if (pop)
        begin
          if (word[0])
          begin
            low_next = word;
            state_next = core_pkg::F_WORD2;
          end
          else
          begin
            ir_next = {32'h0, word};
            pc_next = fetch_pc;
            fetch_pc_next = fetch_pc + 32'd4;
          end
        end
      core_pkg::F_WORD2:
        if (pop)
        begin
          ir_next = {word, low}; // immediate in upper half
          pc_next = fetch_pc;
          fetch_pc_next = fetch_pc + 32'd8;
          state_next = core_pkg::F_WORD1;
        end
      default:
        state_next = core_pkg::F_RESET;
    endcase
    if (pc_set_i)
    begin
      ir_next = '0;
      fetch_pc_next = pc_in_i;
      state_next = core_pkg::F_RESET;
    end
  end

endmodule

`default_nettype wire

// File: hdl/decode.sv
`default_nettype none
`timescale 1ns/1ps

module decode
(
  input  wire             clk_i,
  input  wire             rst_i,
  fetch_if.dst            fi,
  input  wire             hold_i,
  input  wire             flush_i,
  output core_pkg::dec_t  dec_o
);

  core_pkg::dec_t dec_next;
  core_pkg::opcode_t op;
  logic [31:0] word;

  assign word = fi.ir[31:0];

  always_comb
  begin
    if (word[4:1] <= core_pkg::OP_HALT)
      op = core_pkg::opcode_t'(word[4:1]);
    else
      op = core_pkg::OP_NOP; // unknown codes
    if (op == core_pkg::OP_JMP && !word[0])
      op = core_pkg::OP_NOP; // jump needs the long form
  end

  always_comb
  begin
    dec_next.valid = |fi.ir;
    dec_next.op = op;
    dec_next.rd = word[11:8];
    dec_next.ra = word[15:12];
    dec_next.rb = word[19:16];
    if (word[0])
      dec_next.imm = fi.ir[63:32];
    else
      dec_next.imm = {{20{word[31]}}, word[31:20]};
    dec_next.pc = fi.pc;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i || flush_i)
    begin
      dec_o.valid <= 1'b0;
      dec_o.op <= core_pkg::OP_NOP;
    end
    else if (!hold_i)
      dec_o <= dec_next;
  end

endmodule

`default_nettype wire

// File: hdl/execute.sv
`default_nettype none
`timescale 1ns/1ps

module execute
(
  input  wire                 clk_i,
  input  wire                 rst_i,
  input  wire core_pkg::dec_t dec_i,
  input  wire                 hold_i,
  rf_if.ctl                   rf,
  output logic                redirect_o,
  output logic [31:0]         target_o,
  output logic                halt_o
);

  logic halted;
  logic accept;
  logic wr;
  logic [31:0] res;

  // once halted nothing else is taken
  assign accept = dec_i.valid && !hold_i && !halted;

  assign rf.ra = dec_i.ra;
  assign rf.rb = dec_i.rb;

  always_comb
  begin
    res = '0;
    wr = 1'b0;
    case (dec_i.op)
      core_pkg::OP_ADD:
      begin
        res = rf.rdata_a + rf.rdata_b;
        wr = 1'b1;
      end
      core_pkg::OP_SUB:
      begin
        res = rf.rdata_a - rf.rdata_b;
        wr = 1'b1;
      end
      core_pkg::OP_AND:
      begin
        res = rf.rdata_a & rf.rdata_b;
        wr = 1'b1;
      end
      core_pkg::OP_OR:
      begin
        res = rf.rdata_a | rf.rdata_b;
        wr = 1'b1;
      end
      core_pkg::OP_XOR:
      begin
        res = rf.rdata_a ^ rf.rdata_b;
        wr = 1'b1;
      end
      core_pkg::OP_LDI:
      begin
        res = dec_i.imm;
        wr = 1'b1;
      end
      default:
        wr = 1'b0; // nop, jmp, halt
    endcase
  end

  assign rf.we = accept && wr;
  assign rf.wa = dec_i.rd;
  assign rf.wd = res;

  assign redirect_o = accept && (dec_i.op == core_pkg::OP_JMP);
  assign target_o = dec_i.imm; // absolute target
  assign halt_o = halted;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      halted <= 1'b0;
    else if (accept && dec_i.op == core_pkg::OP_HALT)
      halted <= 1'b1; // sticky
  end

endmodule

`default_nettype wire

// File: hdl/result.sv
`default_nettype none
`timescale 1ns/1ps

module result
(
  input  wire         clk_i,
  input  wire         rst_i,
  rf_if.regs          rf,
  output logic        retire_o,
  output logic [3:0]  retire_reg_o,
  output logic [31:0] retire_data_o
);

  logic [31:0] regs [core_pkg::NREGS];
  logic        wr_valid;
  logic [3:0]  wr_addr;
  logic [31:0] wr_data;

  // pending write wins over the array
  assign rf.rdata_a = (wr_valid && wr_addr == rf.ra) ? wr_data : regs[rf.ra];
  assign rf.rdata_b = (wr_valid && wr_addr == rf.rb) ? wr_data : regs[rf.rb];

  assign retire_o = wr_valid;
  assign retire_reg_o = wr_addr;
  assign retire_data_o = wr_data;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      wr_valid <= 1'b0;
    else
      wr_valid <= rf.we;
  end

  always_ff @(posedge clk_i)
  begin
    wr_addr <= rf.wa;
    wr_data <= rf.wd;
    if (wr_valid)
      regs[wr_addr] <= wr_data; // commit
  end

endmodule

`default_nettype wire

// File: hdl/core_top.sv
`default_nettype none
`timescale 1ns/1ps

module core_top
(
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire         hold_i,
  output logic        wb_cyc_o,
  output logic        wb_stb_o,
  output logic        wb_we_o,
  output logic [3:0]  wb_sel_o,
  output logic [31:0] wb_adr_o,
  input  wire  [31:0] wb_dat_i,
  input  wire         wb_ack_i,
  input  wire         wb_stall_i,
  output logic        retire_o,
  output logic [3:0]  retire_reg_o,
  output logic [31:0] retire_data_o,
  output logic        halted_o
);

  wb_if    wb ();
  fetch_if fo ();
  rf_if    rf ();

  core_pkg::dec_t dec;
  logic redirect;
  logic [31:0] target;
  logic halt;

  assign wb_cyc_o = wb.cyc;
  assign wb_stb_o = wb.stb;
  assign wb_we_o = wb.we;
  assign wb_sel_o = wb.sel;
  assign wb_adr_o = wb.adr;
  assign wb.dat_s = wb_dat_i;
  assign wb.ack = wb_ack_i;
  assign wb.stall = wb_stall_i;
  assign halted_o = halt;

  ifetch u_ifetch (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .bus      (wb),
    .fo       (fo),
    .pc_set_i (redirect),
    .pc_in_i  (target),
    .halt_i   (halt),
    .stall_i  (hold_i)
  );

  decode u_decode (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .fi      (fo),
    .hold_i  (hold_i),
    .flush_i (redirect),
    .dec_o   (dec)
  );

  execute u_execute (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .dec_i      (dec),
    .hold_i     (hold_i),
    .rf         (rf),
    .redirect_o (redirect),
    .target_o   (target),
    .halt_o     (halt)
  );

  result u_result (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .rf            (rf),
    .retire_o      (retire_o),
    .retire_reg_o  (retire_reg_o),
    .retire_data_o (retire_data_o)
  );

endmodule

`default_nettype wire

// File: tb/tb_mem.sv
`default_nettype none
`timescale 1ns/1ps

module tb_mem
(
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire         cyc_i,
  input  wire         stb_i,
  input  wire  [31:0] adr_i,
  output logic [31:0] dat_o,
  output logic        ack_o,
  output logic        stall_o
);

  localparam int PROG_WORDS = 32;

  logic [31:0] prog [PROG_WORDS];
  logic [31:0] q_adr [$]; // accepted requests, oldest first
  int          q_due [$];
  int          cycle;
  integer      seed;
  logic        in_reset;

  function automatic logic [31:0] enc(input logic [3:0] op, input logic lng,
                                      input logic [3:0] rd, input logic [3:0] ra,
                                      input logic [3:0] rb, input logic [11:0] imm);
    return {imm, rb, ra, rd, 3'b000, op, lng};
  endfunction

  // depends on every address bit
  function automatic logic [31:0] fill(input logic [31:0] adr);
    return (adr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] adr);
    logic [31:0] offs;
    offs = adr - core_pkg::START_ADDR;
    if (adr >= core_pkg::START_ADDR && offs < 4 * PROG_WORDS)
      return prog[offs[6:2]];
    return fill(adr);
  endfunction

  initial
  begin
    seed = 86216;
    cycle = 0;
    ack_o = 1'b0;
    stall_o = 1'b0;
    dat_o = '0;
    for (int i = 0; i < PROG_WORDS; i++)
      prog[i] = fill(core_pkg::START_ADDR + 32'(4 * i));
    prog[0]  = enc(4'd6, 1'b0, 4'd1, 4'd0, 4'd0, 12'd5);    // ldi r1, 5
    prog[1]  = enc(4'd6, 1'b0, 4'd2, 4'd0, 4'd0, 12'hffd);  // ldi r2, -3
    prog[2]  = enc(4'd1, 1'b0, 4'd3, 4'd1, 4'd2, 12'd0);    // add r3 needs bypass
    prog[3]  = enc(4'd0, 1'b0, 4'd3, 4'd0, 4'd0, 12'd0);    // nop
    prog[4]  = enc(4'd6, 1'b1, 4'd4, 4'd0, 4'd0, 12'd0);    // long ldi r4
    prog[5]  = 32'h1234_5678;
    prog[6]  = enc(4'd2, 1'b0, 4'd5, 4'd4, 4'd3, 12'd0);    // sub
    prog[7]  = enc(4'd3, 1'b0, 4'd6, 4'd5, 4'd4, 12'd0);    // and
    prog[8]  = enc(4'd4, 1'b0, 4'd7, 4'd6, 4'd1, 12'd0);    // or
    prog[9]  = enc(4'd5, 1'b0, 4'd8, 4'd7, 4'd5, 12'd0);    // xor
    prog[10] = enc(4'd7, 1'b1, 4'd0, 4'd0, 4'd0, 12'd0);    // jmp
    prog[11] = 32'h0000_0140;
    for (int i = 12; i < 16; i++)
      prog[i] = enc(4'd6, 1'b0, 4'd15, 4'd0, 4'd0, 12'h666); // skipped by the jump
    prog[16] = enc(4'd1, 1'b0, 4'd9, 4'd8, 4'd8, 12'd0);    // jump target
    prog[17] = enc(4'd6, 1'b1, 4'd10, 4'd0, 4'd0, 12'd0);
    prog[18] = 32'hdead_beef;
    prog[19] = enc(4'd5, 1'b0, 4'd11, 4'd10, 4'd9, 12'd0);
    prog[20] = enc(4'd1, 1'b0, 4'd11, 4'd11, 4'd11, 12'd0);
    prog[21] = enc(4'd2, 1'b0, 4'd12, 4'd11, 4'd1, 12'd0);
    prog[22] = enc(4'd8, 1'b0, 4'd0, 4'd0, 4'd0, 12'd0);    // halt
    for (int i = 23; i < 26; i++)
      prog[i] = enc(4'd6, 1'b0, 4'd15, 4'd0, 4'd0, 12'h555); // past the halt
  end

  always @(posedge clk_i)
  begin
    cycle++;
    in_reset = rst_i; // taken at the edge
    if (in_reset)
    begin
      q_adr.delete();
      q_due.delete();
    end
    else
    begin
      if (ack_o)
      begin
        void'(q_adr.pop_front());
        void'(q_due.pop_front());
      end
      if (cyc_i && stb_i && !stall_o)
      begin
        q_adr.push_back(adr_i);
        q_due.push_back(cycle + int'($unsigned($random(seed)) % 3));
      end
    end
    #2;
    stall_o = !in_reset && ($unsigned($random(seed)) % 4 == 0);
    if (!in_reset && q_adr.size() > 0 && q_due[0] <= cycle &&
        $unsigned($random(seed)) % 4 != 0)
    begin
      ack_o = 1'b1;
      dat_o = read_word(q_adr[0]);
    end
    else
    begin
      ack_o = 1'b0;
      dat_o = '0;
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_core.sv
`default_nettype none
`timescale 1ns/1ps

module tb_core;

  localparam int CLK_PERIOD = 40;
  localparam int WATCHDOG_CYCLES = 4000;
  localparam logic [31:0] JMP_TARGET = 32'h0000_0140;

  logic        clk;
  logic        rst;
  logic        hold;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [3:0]  wb_sel;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat;
  logic        wb_ack;
  logic        wb_stall;
  logic        retire;
  logic [3:0]  retire_reg;
  logic [31:0] retire_data;
  logic        halted;

  logic [3:0]  exp_reg [$];
  logic [31:0] exp_data [$];
  integer      seed;
  int          accepts;
  int          acks;
  int          post_cnt;
  int          jump_left; // expected retires from the jump target on
  logic        in_reset;
  logic        prev_hold;
  logic        halted_seen;
  logic        stb_seen;
  logic        first_req_seen;
  logic        target_req_seen;

  core_top u_core_top (
    .clk_i         (clk),
    .rst_i         (rst),
    .hold_i        (hold),
    .wb_cyc_o      (wb_cyc),
    .wb_stb_o      (wb_stb),
    .wb_we_o       (wb_we),
    .wb_sel_o      (wb_sel),
    .wb_adr_o      (wb_adr),
    .wb_dat_i      (wb_dat),
    .wb_ack_i      (wb_ack),
    .wb_stall_i    (wb_stall),
    .retire_o      (retire),
    .retire_reg_o  (retire_reg),
    .retire_data_o (retire_data),
    .halted_o      (halted)
  );

  tb_mem u_mem (
    .clk_i   (clk),
    .rst_i   (rst),
    .cyc_i   (wb_cyc),
    .stb_i   (wb_stb),
    .adr_i   (wb_adr),
    .dat_o   (wb_dat),
    .ack_o   (wb_ack),
    .stall_o (wb_stall)
  );

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  // walks the program as the instruction set defines it
  task automatic build_expected();
    logic [31:0] regs [16];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] imm;
    logic [31:0] res;
    logic [3:0]  op;
    logic        wr;
    logic        done;
    int          idx;
    int          steps;
    int          jump_at;
    for (int i = 0; i < 16; i++)
      regs[i] = '0;
    pc = core_pkg::START_ADDR;
    done = 1'b0;
    steps = 0;
    jump_at = 0;
    while (!done && steps < 64)
    begin
      idx = int'((pc - core_pkg::START_ADDR) >> 2);
      w = u_mem.prog[idx];
      op = w[4:1];
      imm = w[0] ? u_mem.prog[idx + 1] : {{20{w[31]}}, w[31:20]};
      pc = pc + (w[0] ? 32'd8 : 32'd4);
      wr = 1'b1;
      res = '0;
      case (op)
        4'd1: res = regs[w[15:12]] + regs[w[19:16]];
        4'd2: res = regs[w[15:12]] - regs[w[19:16]];
        4'd3: res = regs[w[15:12]] & regs[w[19:16]];
        4'd4: res = regs[w[15:12]] | regs[w[19:16]];
        4'd5: res = regs[w[15:12]] ^ regs[w[19:16]];
        4'd6: res = imm;
        4'd7:
        begin
          wr = 1'b0;
          if (w[0])
          begin
            pc = imm; // short form is a nop
            jump_at = exp_reg.size();
          end
        end
        4'd8:
        begin
          wr = 1'b0;
          done = 1'b1;
        end
        default: wr = 1'b0;
      endcase
      if (wr)
      begin
        regs[w[11:8]] = res;
        exp_reg.push_back(w[11:8]);
        exp_data.push_back(res);
      end
      steps++;
    end
    jump_left = exp_reg.size() - jump_at;
  endtask

  always #(CLK_PERIOD / 2) clk = ~clk;

  // random hold, driven just after the edge
  always @(posedge clk)
  begin
    in_reset = rst;
    #2;
    hold = !in_reset && ($unsigned($random(seed)) % 5 == 0);
  end

  always @(negedge clk)
  begin
    if (rst)
    begin
      post_cnt = 0;
      assert (!wb_cyc && !wb_stb && !retire && !halted)
        else stop_with_failure($sformatf("FAIL %0d ns: outputs not low in reset", $time));
    end
    else
    begin
      post_cnt++;
      if (post_cnt == 1)
        assert (!wb_cyc && !wb_stb && !retire && !halted)
          else stop_with_failure($sformatf("FAIL %0d ns: outputs not low after reset", $time));
      if (wb_stb)
        stb_seen = 1'b1;
      if (post_cnt == 2)
        assert (stb_seen)
          else stop_with_failure($sformatf("FAIL %0d ns: no stb within 2 cycles", $time));
      assert (!wb_we && wb_sel == 4'hf)
        else stop_with_failure($sformatf("FAIL %0d ns: we=%b sel=%h", $time, wb_we, wb_sel));
      if (wb_cyc && wb_stb && !wb_stall)
      begin
        if (!first_req_seen)
          assert (wb_adr == core_pkg::START_ADDR)
            else stop_with_failure($sformatf("FAIL %0d ns: first request at %h",
                                             $time, wb_adr));
        first_req_seen = 1'b1;
        if (wb_adr == JMP_TARGET && exp_reg.size() == jump_left)
          target_req_seen = 1'b1; // after the jump, before the target retires
        accepts++;
      end
      if (wb_ack)
        acks++;
      assert (acks <= accepts)
        else stop_with_failure($sformatf("FAIL %0d ns: %0d acks for %0d requests",
                                         $time, acks, accepts));
      if (retire)
      begin
        assert (!prev_hold)
          else stop_with_failure($sformatf("FAIL %0d ns: retire after a held cycle", $time));
        assert (exp_reg.size() > 0)
          else stop_with_failure($sformatf("FAIL %0d ns: extra retire r%0d=%h",
                                           $time, retire_reg, retire_data));
        assert (retire_reg == exp_reg[0] && retire_data == exp_data[0])
          else stop_with_failure($sformatf("FAIL %0d ns: retire r%0d=%h, expected r%0d=%h",
                                           $time, retire_reg, retire_data,
                                           exp_reg[0], exp_data[0]));
        void'(exp_reg.pop_front());
        void'(exp_data.pop_front());
      end
      if (halted_seen)
        assert (halted && !retire && !wb_stb)
          else stop_with_failure($sformatf("FAIL %0d ns: activity after halt", $time));
      if (halted)
        halted_seen = 1'b1;
    end
    prev_hold = hold;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_with_failure("timeout: the core did not halt with all expected retires in time");
  end

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    hold = 1'b0;
    seed = 86216;
    accepts = 0;
    acks = 0;
    post_cnt = 0;
    jump_left = 0;
    prev_hold = 1'b0;
    halted_seen = 1'b0;
    stb_seen = 1'b0;
    first_req_seen = 1'b0;
    target_req_seen = 1'b0;
    #1;
    build_expected();
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    while (!(halted_seen && exp_reg.size() == 0 && accepts == acks))
      @(negedge clk);
    repeat (20) @(negedge clk); // halt must stay quiet
    assert (target_req_seen)
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
    else
      stop_with_failure("the jump target was not requested after the jump");
  end

endmodule

`default_nettype wire

// File: wbcore.f
hdl/core_pkg.sv
hdl/core_ifs.sv
hdl/fetch_fifo.sv
hdl/ifetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/result.sv
hdl/core_top.sv
tb/tb_mem.sv
tb/tb_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator, then check the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f wbcore.f --top-module tb_core --Mdir obj_dir -o tb_core_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_core_sim > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0
